/* sources.f */
design/axil_pkg.sv
design/sample_buf_pkg.sv
design/axil_sram_adapter.sv
design/sample_dpram.sv
design/sample_capture.sv
design/sample_playback.sv
design/sample_buffer_top.sv
verif/sample_buffer_checker.sv
verif/sample_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module sample_buffer_tb \
	-f sources.f -o sample_buffer_sim

# A failing run is judged from the log below
./obj_dir/sample_buffer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation finished cleanly"

/* verif/sample_buffer_tb.sv */
`timescale 1ns/1ps

module sample_buffer_tb
	import axil_pkg::*;
	import sample_buf_pkg::*;
();

	localparam int TIMEOUT = 50; // Cycles per wait

	typedef enum {OP_WRITE, OP_READ, OP_CAPTURE, OP_SWEEP, OP_FILL, OP_PLAY} op_e;

	typedef struct {
		op_e        op;
		int         idx;  // Word index, or a count for stream runs
		axil_data_t data; // Bus data, or the base value of a run
		axil_strb_t strb;
		axil_data_t exp;  // Expected read data
	} stim_t;

	logic       clk_i;
	logic       rst_ni;
	logic       s_awvalid_i, s_wvalid_i, s_bready_i, s_arvalid_i, s_rready_i;
	logic       s_awready_o, s_wready_o, s_bvalid_o, s_arready_o, s_rvalid_o;
	axil_addr_t s_awaddr_i, s_araddr_i;
	axil_data_t s_wdata_i, s_rdata_o;
	axil_strb_t s_wstrb_i;
	axil_resp_t s_bresp_o, s_rresp_o;
	logic       sample_valid_i, play_req_i, play_valid_o;
	sample_t    sample_i, play_sample_o;

	stim_t   stim_q[$];
	sample_t ref_mem[SAMPLE_DEPTH]; // Reference copy of the RAM
	int      ref_wr_ptr = 0;
	int      ref_rd_ptr = 0;
	integer  seed = 14;

	sample_buffer_top u_sample_buffer_top (.*);

	bind axil_sram_adapter sample_buffer_checker u_checker (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.awready_i (s_awready_o),
		.wready_i  (s_wready_o),
		.arvalid_i (s_arvalid_i),
		.arready_i (s_arready_o),
		.bvalid_i  (s_bvalid_o),
		.bready_i  (s_bready_i),
		.bresp_i   (s_bresp_o),
		.rvalid_i  (s_rvalid_o),
		.rready_i  (s_rready_i),
		.rdata_i   (s_rdata_o)
	);

	initial clk_i = 1'b0;
	always #5 clk_i = ~clk_i;

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_error(input string msg);
		$display("ERROR at %0t: %s", $time, msg);
		abort_run();
	endtask

	task automatic check_bus_data(input string name, input axil_data_t exp, input axil_data_t act);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	function automatic logic sig_high(input string what);
		case (what)
			"awready": return s_awready_o && s_wready_o;
			"arready": return s_arready_o;
			"bvalid":  return s_bvalid_o;
			default:   return s_rvalid_o;
		endcase
	endfunction

	// Sampled at the falling edge where inputs are steady
	task automatic wait_for(input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (!sig_high(what) && n < TIMEOUT);
		if (!sig_high(what)) report_error({"timeout waiting for ", what});
	endtask

	// Random stall on the response channel during which nothing new is accepted
	task automatic hold_response(input bit is_read);
		int         stall;
		axil_data_t held_data;
		axil_resp_t held_resp;
		stall = $random(seed) & 7;
		held_data = s_rdata_o;
		held_resp = is_read ? s_rresp_o : s_bresp_o;
		repeat (stall) begin
			@(negedge clk_i);
			if (is_read) begin
				check_flag("s_rvalid_o", 1'b1, s_rvalid_o);
				check_bus_data("s_rdata_o", held_data, s_rdata_o);
				check_resp("s_rresp_o", held_resp, s_rresp_o);
			end else begin
				check_flag("s_bvalid_o", 1'b1, s_bvalid_o);
				check_resp("s_bresp_o", held_resp, s_bresp_o);
			end
			check_flag("s_awready_o", 1'b0, s_awready_o);
			check_flag("s_wready_o", 1'b0, s_wready_o);
			check_flag("s_arready_o", 1'b0, s_arready_o);
		end
	endtask

	task automatic bus_write(input int idx, input axil_data_t data, input axil_strb_t strb);
		@(posedge clk_i);
		s_awvalid_i <= 1'b1;
		s_awaddr_i  <= axil_addr_t'(idx * 4);
		s_wvalid_i  <= 1'b1;
		s_wdata_i   <= data;
		s_wstrb_i   <= strb;
		wait_for("awready");
		@(posedge clk_i); // AW and W transfer here
		s_awvalid_i <= 1'b0;
		s_wvalid_i  <= 1'b0;
		wait_for("bvalid");
		hold_response(1'b0);
		check_resp("s_bresp_o", RESP_OKAY, s_bresp_o);
		@(posedge clk_i);
		s_bready_i <= 1'b1;
		@(posedge clk_i);
		s_bready_i <= 1'b0;
	endtask

	task automatic bus_read(input int idx, output axil_data_t data);
		@(posedge clk_i);
		s_arvalid_i <= 1'b1;
		s_araddr_i  <= axil_addr_t'(idx * 4);
		wait_for("arready");
		@(posedge clk_i);
		s_arvalid_i <= 1'b0;
		wait_for("rvalid");
		hold_response(1'b1);
		check_resp("s_rresp_o", RESP_OKAY, s_rresp_o);
		data = s_rdata_o;
		@(posedge clk_i);
		s_rready_i <= 1'b1;
		@(posedge clk_i);
		s_rready_i <= 1'b0;
	endtask

	// Word index from bits 2 and up and byte select from strobe bits 0 and 1
	task automatic model_write(input int idx, input axil_data_t data, input axil_strb_t strb);
		int w;
		w = idx % SAMPLE_DEPTH;
		if (strb[0]) ref_mem[w][7:0] = data[7:0];
		if (strb[1]) ref_mem[w][15:8] = data[15:8];
	endtask

	task automatic capture_run(input int count, input sample_t base);
		int      i;
		sample_t v;
		for (i = 0; i < count; i++) begin
			v = base + sample_t'(i * 16'h0111);
			@(posedge clk_i);
			sample_valid_i <= 1'b1;
			sample_i       <= v;
			ref_mem[ref_wr_ptr] = v;
			ref_wr_ptr = (ref_wr_ptr + 1) % SAMPLE_DEPTH;
		end
		@(posedge clk_i);
		sample_valid_i <= 1'b0;
	endtask

	// play_valid_o must follow each request by exactly one edge
	task automatic playback_run(input int count);
		int i;
		for (i = 0; i <= count + 1; i++) begin
			@(posedge clk_i);
			play_req_i <= (i < count);
			@(negedge clk_i);
			if (i >= 1 && i <= count) begin
				check_flag("play_valid_o", 1'b1, play_valid_o);
				check_sample("play_sample_o", ref_mem[ref_rd_ptr], play_sample_o);
				ref_rd_ptr = (ref_rd_ptr + 1) % SAMPLE_DEPTH;
			end else begin
				check_flag("play_valid_o", 1'b0, play_valid_o);
			end
		end
	endtask

	task automatic add_step(input op_e op, input int idx, input axil_data_t data,
			input axil_strb_t strb, input axil_data_t exp);
		stim_t s;
		s.op = op;
		s.idx = idx;
		s.data = data;
		s.strb = strb;
		s.exp = exp;
		stim_q.push_back(s);
	endtask

	task automatic apply_step(input stim_t s);
		axil_data_t   rdata;
		sample_addr_t w;
		int           i;
		case (s.op)
			OP_WRITE: begin
				bus_write(s.idx, s.data, s.strb);
				model_write(s.idx, s.data, s.strb);
			end
			OP_READ: begin
				bus_read(s.idx, rdata);
				check_bus_data("s_rdata_o", s.exp, rdata);
			end
			OP_CAPTURE: capture_run(s.idx, sample_t'(s.data));
			OP_SWEEP: begin
				for (i = 0; i < SAMPLE_DEPTH; i++) begin
					bus_read(i, rdata);
					check_bus_data("s_rdata_o", axil_data_t'(ref_mem[i]), rdata);
				end
			end
			OP_FILL: begin
				for (i = 0; i < SAMPLE_DEPTH; i++) begin
					w = sample_addr_t'(i);
					bus_write(i, s.data ^ axil_data_t'({w, ~w, w[3:0]}), 4'hF);
					model_write(i, s.data ^ axil_data_t'({w, ~w, w[3:0]}), 4'hF);
				end
			end
			default: playback_run(s.idx);
		endcase
	endtask

	task automatic check_idle_outputs();
		@(negedge clk_i);
		check_flag("s_bvalid_o", 1'b0, s_bvalid_o);
		check_flag("s_rvalid_o", 1'b0, s_rvalid_o);
		check_flag("play_valid_o", 1'b0, play_valid_o);
	endtask

	initial begin
		rst_ni         <= 1'b0;
		s_awvalid_i    <= 1'b0;
		s_awaddr_i     <= '0;
		s_wvalid_i     <= 1'b0;
		s_wdata_i      <= '0;
		s_wstrb_i      <= '0;
		s_bready_i     <= 1'b0;
		s_arvalid_i    <= 1'b0;
		s_araddr_i     <= '0;
		s_rready_i     <= 1'b0;
		sample_valid_i <= 1'b0;
		sample_i       <= '0;
		play_req_i     <= 1'b0;

		// Full write, then byte strobes, ignored upper strobes and aliasing
		add_step(OP_WRITE, 3, 32'hDEAD_BEEF, 4'hF, '0);
		add_step(OP_READ, 3, '0, '0, 32'h0000_BEEF);
		add_step(OP_WRITE, 3, 32'h0000_12AA, 4'h1, '0);
		add_step(OP_READ, 3, '0, '0, 32'h0000_BEAA);
		add_step(OP_WRITE, 3, 32'h0000_55CC, 4'h2, '0);
		add_step(OP_WRITE, 3, 32'h7777_0000, 4'hC, '0);
		add_step(OP_READ, 3, '0, '0, 32'h0000_55AA);
		add_step(OP_WRITE, 69, 32'hABCD_1234, 4'hF, '0);
		add_step(OP_READ, 5, '0, '0, 32'h0000_1234);
		add_step(OP_READ, 133, '0, '0, 32'h0000_1234);
		add_step(OP_CAPTURE, 70, 32'h0000_A000, '0, '0); // Wraps the write pointer
		add_step(OP_SWEEP, 0, '0, '0, '0);
		add_step(OP_FILL, 0, 32'h0000_3C5A, '0, '0);
		add_step(OP_PLAY, 70, '0, '0, '0); // Wraps the read pointer

		repeat (2) @(posedge clk_i);
		check_idle_outputs(); // Still in reset
		repeat (8) @(posedge clk_i);
		rst_ni <= 1'b1;
		check_idle_outputs();

		foreach (stim_q[k]) begin
			apply_step(stim_q[k]);
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* verif/sample_buffer_checker.sv */
`timescale 1ns/1ps

module sample_buffer_checker
	import axil_pkg::*;
	import sample_buf_pkg::*;
(
	input logic       clk_i,
	input logic       rst_ni,
	input logic       awready_i,
	input logic       wready_i,
	input logic       arvalid_i,
	input logic       arready_i,
	input logic       bvalid_i,
	input logic       bready_i,
	input axil_resp_t bresp_i,
	input logic       rvalid_i,
	input logic       rready_i,
	input axil_data_t rdata_i
);

	// B channel holds until the master takes it
	b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
		else $error("Write response dropped or changed before bready");

	r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
		else $error("Read response dropped or changed before rready");

	// Single outstanding transaction
	no_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(bvalid_i || rvalid_i) |-> !(awready_i || wready_i || arready_i))
		else $error("Ready raised while a response is pending");

	rd_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$past(arvalid_i && arready_i, 3) |-> rvalid_i && !$past(rvalid_i))
		else $error("rvalid did not rise two edges after the AR transfer");

endmodule

/* design/sample_buffer_top.sv */
`timescale 1ns/1ps

module sample_buffer_top
	import axil_pkg::*;
	import sample_buf_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,

	// AXI4-Lite slave
	input  logic       s_awvalid_i,
	output logic       s_awready_o,
	input  axil_addr_t s_awaddr_i,
	input  logic       s_wvalid_i,
	output logic       s_wready_o,
	input  axil_data_t s_wdata_i,
	input  axil_strb_t s_wstrb_i,
	output logic       s_bvalid_o,
	input  logic       s_bready_i,
	output axil_resp_t s_bresp_o,
	input  logic       s_arvalid_i,
	output logic       s_arready_o,
	input  axil_addr_t s_araddr_i,
	output logic       s_rvalid_o,
	input  logic       s_rready_i,
	output axil_data_t s_rdata_o,
	output axil_resp_t s_rresp_o,

	// Sample streams
	input  logic       sample_valid_i,
	input  sample_t    sample_i,
	input  logic       play_req_i,
	output logic       play_valid_o,
	output sample_t    play_sample_o
);

	// Adapter to RAM
	logic                  bus_req;
	logic                  bus_we;
	sample_addr_t          bus_addr;
	sample_t               bus_wdata;
	logic [SAMPLE_W/8-1:0] bus_wmask;
	sample_t               bus_rdata;
	logic                  bus_rvalid;

	// Streams to RAM
	logic         cap_we;
	sample_addr_t cap_addr;
	sample_t      cap_data;
	logic         pb_en;
	sample_addr_t pb_addr;
	sample_t      pb_rdata;

	axil_sram_adapter u_axil_sram_adapter (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.s_awvalid_i  (s_awvalid_i),
		.s_awready_o  (s_awready_o),
		.s_awaddr_i   (s_awaddr_i),
		.s_wvalid_i   (s_wvalid_i),
		.s_wready_o   (s_wready_o),
		.s_wdata_i    (s_wdata_i),
		.s_wstrb_i    (s_wstrb_i),
		.s_bvalid_o   (s_bvalid_o),
		.s_bready_i   (s_bready_i),
		.s_bresp_o    (s_bresp_o),
		.s_arvalid_i  (s_arvalid_i),
		.s_arready_o  (s_arready_o),
		.s_araddr_i   (s_araddr_i),
		.s_rvalid_o   (s_rvalid_o),
		.s_rready_i   (s_rready_i),
		.s_rdata_o    (s_rdata_o),
		.s_rresp_o    (s_rresp_o),
		.ram_req_o    (bus_req),
		.ram_we_o     (bus_we),
		.ram_addr_o   (bus_addr),
		.ram_wdata_o  (bus_wdata),
		.ram_wmask_o  (bus_wmask),
		.ram_rdata_i  (bus_rdata),
		.ram_rvalid_i (bus_rvalid)
	);

	sample_dpram u_sample_dpram (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.cap_we_i     (cap_we),
		.cap_addr_i   (cap_addr),
		.cap_data_i   (cap_data),
		.pb_en_i      (pb_en),
		.pb_addr_i    (pb_addr),
		.pb_rdata_o   (pb_rdata),
		.bus_req_i    (bus_req),
		.bus_we_i     (bus_we),
		.bus_addr_i   (bus_addr),
		.bus_wdata_i  (bus_wdata),
		.bus_wmask_i  (bus_wmask),
		.bus_rdata_o  (bus_rdata),
		.bus_rvalid_o (bus_rvalid)
	);

	sample_capture u_sample_capture (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.sample_valid_i (sample_valid_i),
		.sample_i       (sample_i),
		.cap_we_o       (cap_we),
		.cap_addr_o     (cap_addr),
		.cap_data_o     (cap_data)
	);

	sample_playback u_sample_playback (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.play_req_i    (play_req_i),
		.pb_en_o       (pb_en),
		.pb_addr_o     (pb_addr),
		.pb_rdata_i    (pb_rdata),
		.play_valid_o  (play_valid_o),
		.play_sample_o (play_sample_o)
	);

endmodule

/* design/sample_playback.sv */
`timescale 1ns/1ps

module sample_playback
	import sample_buf_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_ni,

	input  logic         play_req_i,

	// RAM port B
	output logic         pb_en_o,
	output sample_addr_t pb_addr_o,
	input  sample_t      pb_rdata_i,

	// Outgoing sample stream
	output logic         play_valid_o,
	output sample_t      play_sample_o
);

	sample_addr_t rd_ptr_q;
	logic         valid_q; // Request delayed to match the RAM read latency

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rd_ptr_q <= '0;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= play_req_i;
			if (play_req_i) begin
				rd_ptr_q <= rd_ptr_q + 1'b1; // Wraps past the last word
			end
		end
	end

	assign pb_en_o   = play_req_i;
	assign pb_addr_o = rd_ptr_q;

	// RAM output register holds the sample
	assign play_valid_o  = valid_q;
	assign play_sample_o = pb_rdata_i;

endmodule

/* design/sample_capture.sv */
`timescale 1ns/1ps

module sample_capture
	import sample_buf_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_ni,

	// Incoming sample stream, never stalled
	input  logic         sample_valid_i,
	input  sample_t      sample_i,

	// RAM port A
	output logic         cap_we_o,
	output sample_addr_t cap_addr_o,
	output sample_t      cap_data_o
);

	sample_addr_t wr_ptr_q;

	// Pointer width equals the RAM index width, so it wraps at the depth
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_ptr_q <= '0;
		end else if (sample_valid_i) begin
			wr_ptr_q <= wr_ptr_q + 1'b1;
		end
	end

	// Sample goes to the current pointer on the same edge
	assign cap_we_o   = sample_valid_i;
	assign cap_addr_o = wr_ptr_q;
	assign cap_data_o = sample_i;

endmodule

/* design/sample_dpram.sv */
`timescale 1ns/1ps

module sample_dpram
	import sample_buf_pkg::*;
(
	input  logic                  clk_i,
	input  logic                  rst_ni,

	// Port A, capture write
	input  logic                  cap_we_i,
	input  sample_addr_t          cap_addr_i,
	input  sample_t               cap_data_i,

	// Port B, playback read
	input  logic                  pb_en_i,
	input  sample_addr_t          pb_addr_i,
	output sample_t               pb_rdata_o,

	// Bus port
	input  logic                  bus_req_i,
	input  logic                  bus_we_i,
	input  sample_addr_t          bus_addr_i,
	input  sample_t               bus_wdata_i,
	input  logic [SAMPLE_W/8-1:0] bus_wmask_i,
	output sample_t               bus_rdata_o,
	output logic                  bus_rvalid_o
);

	sample_t mem [SAMPLE_DEPTH];

	// Both write ports share one process, bus write lands last
	always_ff @(posedge clk_i) begin
		if (cap_we_i) begin
			mem[cap_addr_i] <= cap_data_i;
		end
		if (bus_req_i && bus_we_i) begin
			for (int b = 0; b < SAMPLE_W / 8; b++) begin
				if (bus_wmask_i[b]) begin
					mem[bus_addr_i][8*b +: 8] <= bus_wdata_i[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (pb_en_i) begin
			pb_rdata_o <= mem[pb_addr_i];
		end
	end

	// Bus read data, qualified by bus_rvalid_o
	always_ff @(posedge clk_i) begin
		if (bus_req_i && !bus_we_i) begin
			bus_rdata_o <= mem[bus_addr_i];
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			bus_rvalid_o <= 1'b0;
		end else begin
			bus_rvalid_o <= bus_req_i && !bus_we_i;
		end
	end

endmodule

/* design/axil_sram_adapter.sv */
`timescale 1ns/1ps

module axil_sram_adapter
	import axil_pkg::*;
	import sample_buf_pkg::*;
(
	input  logic         clk_i,
	input  logic         rst_ni,

	// AXI4-Lite slave
	input  logic         s_awvalid_i,
	output logic         s_awready_o,
	input  axil_addr_t   s_awaddr_i,
	input  logic         s_wvalid_i,
	output logic         s_wready_o,
	input  axil_data_t   s_wdata_i,
	input  axil_strb_t   s_wstrb_i,
	output logic         s_bvalid_o,
	input  logic         s_bready_i,
	output axil_resp_t   s_bresp_o,
	input  logic         s_arvalid_i,
	output logic         s_arready_o,
	input  axil_addr_t   s_araddr_i,
	output logic         s_rvalid_o,
	input  logic         s_rready_i,
	output axil_data_t   s_rdata_o,
	output axil_resp_t   s_rresp_o,

	// RAM bus port, always granted
	output logic         ram_req_o,
	output logic         ram_we_o,
	output sample_addr_t ram_addr_o,
	output sample_t      ram_wdata_o,
	output logic [1:0]   ram_wmask_o,
	input  sample_t      ram_rdata_i,
	input  logic         ram_rvalid_i
);

	typedef enum logic [2:0] {
		IDLE,
		WR_EXEC,
		WR_RESP,
		RD_EXEC,
		RD_WAIT,
		RD_RESP
	} state_e;

	state_e       state_q, state_d;
	sample_addr_t addr_q;  // Word index, bits above the RAM depth wrap
	sample_t      wdata_q;
	logic [1:0]   wmask_q; // Strobe bits 2 and 3 fall away here
	sample_t      rdata_q;
	logic         bvalid_q;
	logic         rvalid_q;
	logic         wr_go;
	logic         rd_ok;

	// Write wins in idle, and only with address and data both present
	assign wr_go = (state_q == IDLE) && s_awvalid_i && s_wvalid_i;
	assign rd_ok = (state_q == IDLE) && !(s_awvalid_i && s_wvalid_i);

	assign s_awready_o = wr_go;
	assign s_wready_o  = wr_go;
	assign s_arready_o = rd_ok;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			IDLE: begin
				if (wr_go) begin
					state_d = WR_EXEC;
				end else if (s_arvalid_i) begin
					state_d = RD_EXEC;
				end
			end
			WR_EXEC: state_d = WR_RESP;
			WR_RESP: begin
				if (bvalid_q && s_bready_i) begin
					state_d = IDLE;
				end
			end
			RD_EXEC: state_d = RD_WAIT;
			RD_WAIT: begin
				if (ram_rvalid_i) begin
					state_d = RD_RESP;
				end
			end
			RD_RESP: begin
				if (rvalid_q && s_rready_i) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q  <= IDLE;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Write response waits one cycle so it lines up with the read latency
			if ((state_q == WR_RESP) && !bvalid_q) begin
				bvalid_q <= 1'b1;
			end else if (bvalid_q && s_bready_i) begin
				bvalid_q <= 1'b0;
			end
			if ((state_q == RD_WAIT) && ram_rvalid_i) begin
				rvalid_q <= 1'b1;
			end else if (rvalid_q && s_rready_i) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	// Request payload and read data
	always_ff @(posedge clk_i) begin
		if (wr_go) begin
			addr_q  <= s_awaddr_i[SAMPLE_AW+1:2];
			wdata_q <= s_wdata_i[SAMPLE_W-1:0];
			wmask_q <= s_wstrb_i[1:0];
		end else if (rd_ok && s_arvalid_i) begin
			addr_q <= s_araddr_i[SAMPLE_AW+1:2];
		end
		if ((state_q == RD_WAIT) && ram_rvalid_i) begin
			rdata_q <= ram_rdata_i;
		end
	end

	// One RAM request per transaction
	assign ram_req_o   = (state_q == WR_EXEC) || (state_q == RD_EXEC);
	assign ram_we_o    = (state_q == WR_EXEC);
	assign ram_addr_o  = addr_q;
	assign ram_wdata_o = wdata_q;
	assign ram_wmask_o = wmask_q;

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = RESP_OKAY;
	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o  = {{(AXIL_DW - SAMPLE_W){1'b0}}, rdata_q}; // Zero-extended sample
	assign s_rresp_o  = RESP_OKAY;

endmodule

/* design/sample_buf_pkg.sv */
package sample_buf_pkg;

	// Sample format
	localparam int unsigned SAMPLE_W = 16;

	// RAM geometry, depth follows the index width
	localparam int unsigned SAMPLE_AW    = 6;
	localparam int unsigned SAMPLE_DEPTH = 2 ** SAMPLE_AW; // 64 entries

	typedef logic [SAMPLE_W-1:0]  sample_t;
	typedef logic [SAMPLE_AW-1:0] sample_addr_t; // Word index into the RAM

endpackage

/* design/axil_pkg.sv */
package axil_pkg;

	// Bus geometry
	localparam int unsigned AXIL_AW = 32; // Byte address
	localparam int unsigned AXIL_DW = 32;

	typedef logic [AXIL_AW-1:0]   axil_addr_t;
	typedef logic [AXIL_DW-1:0]   axil_data_t;
	typedef logic [AXIL_DW/8-1:0] axil_strb_t; // One strobe per byte lane
	typedef logic [1:0]           axil_resp_t;

	// Only OKAY is ever returned
	localparam axil_resp_t RESP_OKAY = 2'b00;

endpackage
